/* dv/wbCodeMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module wbCodeMemory import z80Pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           wbCyc,
    input  wire           wbStb,
    input  wire codeAddrT wbAdr,
    output codeByteT      wbDatRd,
    output logic          wbAck
);

    localparam int Depth = 65536;
    // region where prefix bytes are planted
    localparam int SeededBytes = 4096;

    codeByteT   mem [0:Depth-1];
    int         memSeed = 52;
    logic [1:0] waitCnt;

    initial begin
        logic [31:0] rnd;
        wbAck = 1'b0;
        wbDatRd = '0;
        waitCnt = '0;
        for (int i = 0; i < Depth; i++) begin
            rnd = $random(memSeed);
            mem[i] = rnd[7:0];
            if (i < SeededBytes && i % 16 == 0) begin
                case (rnd[9:8])
                    2'd0: mem[i] = 8'hDD;
                    2'd1: mem[i] = 8'hED;
                    default: mem[i] = 8'hFD;
                endcase
            end else if (i < SeededBytes && i % 8 == 0) begin
                mem[i] = 8'hCB;
            end
        end
    end

    always @(posedge clk) begin
        logic [31:0] rnd;
        if (rst) begin
            wbAck <= 1'b0;
            waitCnt <= '0;
        end else if (wbAck) begin
            // master drops the cycle on the ack, pick the next latency
            wbAck <= 1'b0;
            rnd = $random(memSeed);
            waitCnt <= rnd[1:0];
        end else if (wbCyc && wbStb) begin
            if (waitCnt == 2'd0) begin
                wbAck <= 1'b1;
                wbDatRd <= mem[wbAdr];
            end else begin
                waitCnt <= waitCnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/z80PredecodeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module z80PredecodeTb import z80Pkg::*; ();

    localparam int NumInstr = 1500;
    localparam int ReadyPercent = 70;
    // up to 3 fetches of at most 6 cycles per instruction, with margin
    localparam int TimeoutCycles = NumInstr * 3 * 6 + 13000;

    logic       clk = 1'b0;
    logic       rst;
    logic       wbCyc;
    logic       wbStb;
    codeAddrT   wbAdr;
    codeByteT   wbDatRd;
    logic       wbAck;
    logic       instrValid;
    logic       instrReady;
    codeAddrT   instrPc;
    instrBytesT instrBytes;
    instrLenT   instrLen;
    instrGroupT instrGroup;

    int         readySeed = 52;
    int         cycles = 0;
    int         doneCnt = 0;
    int         passTests = 0;
    int         failTests = 0;
    int         errCnt [1:6];
    int         seenCnt [1:6];
    codeAddrT   modelPc = 16'h0000;
    logic       stalled = 1'b0;
    // reads completed for the instruction at modelPc
    int         fetchIdx = 0;
    codeAddrT   heldPc;
    instrBytesT heldBytes;
    instrLenT   heldLen;
    instrGroupT heldGroup;

    z80Predecode u_dut (.*);

    wbCodeMemory u_mem (.*);

    always #2 clk = ~clk;

    function automatic instrLenT modelLen(input codeByteT op);
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
        x = op[7:6];
        y = op[5:3];
        z = op[2:0];
        if ((x == 2'd0 && z == 3'd1 && !y[0]) || (x == 2'd0 && z == 3'd2 && y[2]))
            return 2'd3;
        if (op == 8'hC3 || op == 8'hCD || (x == 2'd3 && (z == 3'd2 || z == 3'd4)))
            return 2'd3;
        if ((x == 2'd0 && z == 3'd6) || (x == 2'd0 && z == 3'd0 && y >= 3'd2))
            return 2'd2;
        if ((x == 2'd3 && z == 3'd6) || op == 8'hD3 || op == 8'hDB || op == 8'hCB)
            return 2'd2;
        return 2'd1;
    endfunction

    function automatic instrGroupT modelGroup(input codeByteT op);
        instrGroupT g;
        case (op[7:6])
            2'd1: g = (op == 8'h76) ? grpControl : grpLoad;
            2'd2: g = grpAlu;
            2'd0: begin
                case (op[2:0])
                    3'd0: g = (op == 8'h00) ? grpControl : (op == 8'h08) ? grpExchange : grpJump;
                    3'd1: g = op[3] ? grpAlu : grpLoad;
                    3'd2, 3'd6: g = grpLoad;
                    3'd7: g = grpAlu;
                    default: g = grpIncDec;
                endcase
            end
            default: begin
                case (op[2:0])
                    3'd0: g = grpReturn;
                    3'd1: g = !op[3] ? grpStack : (op == 8'hC9) ? grpReturn :
                              (op == 8'hD9) ? grpExchange : (op == 8'hE9) ? grpJump : grpLoad;
                    3'd2: g = grpJump;
                    3'd3: g = (op == 8'hC3) ? grpJump : (op == 8'hCB) ? grpCbPrefix :
                              (op == 8'hE3 || op == 8'hEB) ? grpExchange : grpControl;
                    3'd5: g = !op[3] ? grpStack : (op == 8'hCD) ? grpCall : grpUnsupported;
                    3'd6: g = grpAlu;
                    default: g = grpCall;
                endcase
            end
        endcase
        return g;
    endfunction

    // second byte of a CB instruction
    function automatic instrGroupT cbModelGroup(input codeByteT b);
        if (b >= 8'hC0)
            return grpSet;
        if (b >= 8'h80)
            return grpRes;
        if (b >= 8'h40)
            return grpBit;
        if (b >= 8'h30 && b <= 8'h37)
            return grpIllegal;
        return grpRotShift;
    endfunction

    function automatic string testLabel(input int t);
        case (t)
            1: return "reset state";
            2: return "unprefixed decode";
            3: return "CB decode";
            4: return "DD/ED/FD prefix";
            5: return "sequencing";
            default: return "back-pressure";
        endcase
    endfunction

    task automatic reportMismatch(input int t, input string sigName,
                                  input logic [31:0] expVal, input logic [31:0] gotVal);
        $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, sigName, expVal, gotVal);
        errCnt[t] = errCnt[t] + 1;
    endtask

    task automatic reportTest(input int t);
        $display("test %0d %s: %0d checked, %0d errors", t, testLabel(t), seenCnt[t], errCnt[t]);
    endtask

    task automatic checkTransfer();
        codeByteT   op;
        codeAddrT   addr;
        instrLenT   expLen;
        instrGroupT expGroup;
        instrBytesT expBytes;
        int         t;
        op = u_mem.mem[modelPc];
        expLen = modelLen(op);
        expGroup = modelGroup(op);
        t = 2;
        if (op == 8'hCB) begin
            expGroup = cbModelGroup(u_mem.mem[modelPc + 16'd1]);
            t = 3;
        end else if (expGroup == grpUnsupported) begin
            t = 4;
        end
        expBytes = '0;
        addr = modelPc;
        for (int k = 0; k < expLen; k++) begin
            expBytes[k*8 +: 8] = u_mem.mem[addr];
            addr = addr + 16'd1;
        end
        seenCnt[t]++;
        seenCnt[5]++;
        if (instrLen !== expLen)
            reportMismatch(t, "instrLen", expLen, instrLen);
        if (instrGroup !== expGroup)
            reportMismatch(t, "instrGroup", expGroup, instrGroup);
        if (instrPc !== modelPc)
            reportMismatch(5, "instrPc", modelPc, instrPc);
        if (instrBytes !== expBytes)
            reportMismatch(5, "instrBytes", expBytes, instrBytes);
        modelPc = modelPc + {14'd0, expLen};
    endtask

    // consumer takes about 70% of the offered instructions
    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $random(readySeed);
        instrReady <= (rnd % 100) < ReadyPercent;
    end

    // outputs are sampled mid-cycle, away from the active edge
    always @(negedge clk) begin
        codeAddrT expAdr;
        if (!rst && doneCnt < NumInstr) begin
            if (stalled) begin
                seenCnt[6]++;
                if (instrValid !== 1'b1)
                    reportMismatch(6, "instrValid", 1, instrValid);
                if (instrPc !== heldPc)
                    reportMismatch(6, "instrPc", heldPc, instrPc);
                if (instrBytes !== heldBytes)
                    reportMismatch(6, "instrBytes", heldBytes, instrBytes);
                if (instrLen !== heldLen)
                    reportMismatch(6, "instrLen", heldLen, instrLen);
                if (instrGroup !== heldGroup)
                    reportMismatch(6, "instrGroup", heldGroup, instrGroup);
            end
            stalled = instrValid && !instrReady;
            if (stalled) begin
                if (wbCyc !== 1'b0)
                    reportMismatch(6, "wbCyc", 0, wbCyc);
                heldPc = instrPc;
                heldBytes = instrBytes;
                heldLen = instrLen;
                heldGroup = instrGroup;
            end
            // reads of one instruction walk up from its first byte
            if (wbCyc && wbAck) begin
                expAdr = modelPc + codeAddrT'(fetchIdx);
                if (wbAdr !== expAdr)
                    reportMismatch(5, "wbAdr", expAdr, wbAdr);
                fetchIdx++;
            end
            if (instrValid && instrReady) begin
                checkTransfer();
                fetchIdx = 0;
                doneCnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("timeout: %0d of %0d instructions after %0d cycles", doneCnt, NumInstr, cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        instrReady = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        seenCnt[1]++;
        if (instrValid !== 1'b0)
            reportMismatch(1, "instrValid", 0, instrValid);
        if (wbCyc !== 1'b0)
            reportMismatch(1, "wbCyc", 0, wbCyc);
        if (wbStb !== 1'b0)
            reportMismatch(1, "wbStb", 0, wbStb);
        // nothing may be offered before the first read is acked
        while (wbAck !== 1'b1)
            @(negedge clk);
        if (instrValid !== 1'b0)
            reportMismatch(1, "instrValid", 0, instrValid);
        reportTest(1);
        wait (doneCnt == NumInstr);
        if (seenCnt[3] == 0) begin
            $display("no CB instruction reached the consumer");
            errCnt[3]++;
        end
        if (seenCnt[4] == 0) begin
            $display("no DD/ED/FD prefix reached the consumer");
            errCnt[4]++;
        end
        if (seenCnt[6] == 0) begin
            $display("the consumer never stalled a valid instruction");
            errCnt[6]++;
        end
        for (int t = 2; t <= 6; t++)
            reportTest(t);
        for (int t = 1; t <= 6; t++) begin
            if (errCnt[t] == 0)
                passTests++;
            else
                failTests++;
        end
        $display("tests: %0d ok, %0d with errors", passTests, failTests);
        if (failTests == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/busFetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module busFetcher import z80Pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           fetchReq,
    input  wire codeAddrT fetchAddr,
    output logic          fetchDone,
    output codeByteT      fetchByte,
    output logic          wbCyc,
    output logic          wbStb,
    output codeAddrT      wbAdr,
    input  wire codeByteT wbDatRd,
    input  wire           wbAck
);

    logic ackSeen;

    assign ackSeen = wbCyc && wbAck;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            if (ackSeen) begin
                // the bus goes idle for at least one cycle after every read
                wbCyc <= 1'b0;
                wbStb <= 1'b0;
                fetchDone <= 1'b1;
            end else if (fetchReq && !wbCyc) begin
                wbCyc <= 1'b1;
                wbStb <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReq && !wbCyc) begin
            wbAdr <= fetchAddr;
        end
        if (ackSeen) begin
            fetchByte <= wbDatRd;
        end
    end

endmodule

`default_nettype wire

/* hdl/cbDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cbDecoder import z80Pkg::*; (
    input  wire codeByteT opcode,
    output instrGroupT    group
);

    always_comb begin
        case (opcode[7:6])
            2'b00: begin
                // 30-37 is the undocumented SLL row
                if (opcode[5:3] == 3'b110) begin
                    group = grpIllegal;
                end else begin
                    group = grpRotShift;
                end
            end
            2'b01:
                group = grpBit;
            2'b10:
                group = grpRes;
            default:
                group = grpSet;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/instrAssembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "z80_cfg.svh"

module instrAssembler import z80Pkg::*; (
    input  wire             clk,
    input  wire             rst,
    output logic            fetchReq,
    output codeAddrT        fetchAddr,
    input  wire             fetchDone,
    input  wire codeByteT   fetchByte,
    output codeByteT        firstByte,
    output codeByteT        secondByte,
    input  wire instrLenT   opLen,
    input  wire instrGroupT opGroup,
    input  wire instrGroupT cbGroup,
    output logic            instrValid,
    input  wire             instrReady,
    output codeAddrT        instrPc,
    output instrBytesT      instrBytes,
    output instrLenT        instrLen,
    output instrGroupT      instrGroup
);

    fetchStateT state;
    // bytes of the current instruction gathered so far
    instrLenT   cnt;
    codeAddrT   nextAddr;
    logic       lastByte;
    instrGroupT finalGroup;

    // decode straight off the fetcher in the cycle the byte arrives
    assign firstByte = (state == stFirst) ? fetchByte : instrBytes[`Z80_DATA_W-1:0];
    assign secondByte = (state == stMore && cnt == 2'd1) ? fetchByte :
                        instrBytes[2*`Z80_DATA_W-1:`Z80_DATA_W];

    assign nextAddr = instrPc + codeAddrT'(cnt) + codeAddrT'(1);
    assign lastByte = (instrLenT'(cnt + 2'd1) == opLen);
    assign finalGroup = (opGroup == grpCbPrefix) ? cbGroup : opGroup;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            fetchReq <= 1'b0;
            instrValid <= 1'b0;
            cnt <= '0;
            // instrPc doubles as the program counter
            instrPc <= codeAddrT'(`Z80_RESET_PC);
        end else begin
            fetchReq <= 1'b0;
            case (state)
                stIdle: begin
                    fetchReq <= 1'b1;
                    state <= stFirst;
                end
                stFirst, stMore: begin
                    if (fetchDone) begin
                        cnt <= instrLenT'(cnt + 2'd1);
                        if (lastByte) begin
                            instrValid <= 1'b1;
                            state <= stHold;
                        end else begin
                            fetchReq <= 1'b1;
                            state <= stMore;
                        end
                    end
                end
                default: begin
                    if (instrReady) begin
                        instrValid <= 1'b0;
                        cnt <= '0;
                        instrPc <= instrPc + codeAddrT'(instrLen);
                        fetchReq <= 1'b1;
                        state <= stFirst;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            stIdle:
                fetchAddr <= instrPc;
            stHold:
                fetchAddr <= instrPc + codeAddrT'(instrLen);
            default:
                fetchAddr <= nextAddr;
        endcase
        if (fetchDone && state == stFirst) begin
            // upper bytes of a short instruction read as zero
            instrBytes <= instrBytesT'(fetchByte);
        end else if (fetchDone && state == stMore) begin
            instrBytes[cnt*`Z80_DATA_W +: `Z80_DATA_W] <= fetchByte;
        end
        if (fetchDone && state != stHold && lastByte) begin
            instrLen <= opLen;
            instrGroup <= finalGroup;
        end
    end

endmodule

`default_nettype wire

/* hdl/opcodeDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder import z80Pkg::*; (
    input  wire codeByteT opcode,
    output instrLenT      len,
    output instrGroupT    group
);

    always_comb begin
        // most opcodes carry no operand
        len = 2'd1;
        group = grpUnsupported;
        // first match wins, so exact opcodes go ahead of the patterns
        case (opcode) inside
            8'h00, 8'h76, 8'hF3, 8'hFB:
                group = grpControl;
            8'hD3, 8'hDB: begin
                group = grpControl;
                len = 2'd2;
            end
            8'h08, 8'hE3, 8'hEB, 8'hD9:
                group = grpExchange;
            8'hCB: begin
                group = grpCbPrefix;
                len = 2'd2;
            end
            8'hDD, 8'hED, 8'hFD:
                group = grpUnsupported;
            8'hC3: begin
                group = grpJump;
                len = 2'd3;
            end
            8'hE9:
                group = grpJump;
            // DJNZ, JR and JR cc take a displacement
            8'h10, 8'h18, 8'b001??000: begin
                group = grpJump;
                len = 2'd2;
            end
            8'hCD: begin
                group = grpCall;
                len = 2'd3;
            end
            8'hC9:
                group = grpReturn;
            8'hF9:
                group = grpLoad;
            8'b00??0001, 8'b001??010: begin
                group = grpLoad;
                len = 2'd3;
            end
            8'b00??1001:
                group = grpAlu;
            8'b000?0010, 8'b000?1010:
                group = grpLoad;
            8'b00???011, 8'b00???10?:
                group = grpIncDec;
            8'b00???110: begin
                group = grpLoad;
                len = 2'd2;
            end
            // rotates on A, DAA, CPL, SCF, CCF
            8'b00???111:
                group = grpAlu;
            8'b01??????:
                group = grpLoad;
            8'b10??????:
                group = grpAlu;
            8'b11???000:
                group = grpReturn;
            8'b11??0001, 8'b11??0101:
                group = grpStack;
            8'b11???010: begin
                group = grpJump;
                len = 2'd3;
            end
            8'b11???100: begin
                group = grpCall;
                len = 2'd3;
            end
            8'b11???110: begin
                group = grpAlu;
                len = 2'd2;
            end
            // RST p
            8'b11???111:
                group = grpCall;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/z80Pkg.sv */
`default_nettype none

`include "z80_cfg.svh"

package z80Pkg;

    typedef logic [`Z80_ADDR_W-1:0] codeAddrT;
    typedef logic [`Z80_DATA_W-1:0] codeByteT;

    // holds 1 to 3
    typedef logic [$clog2(`Z80_MAX_LEN+1)-1:0] instrLenT;

    // byte 0 sits in the low bits
    typedef logic [`Z80_MAX_LEN*`Z80_DATA_W-1:0] instrBytesT;

    typedef enum logic [3:0] {
        grpLoad,
        grpIncDec,
        grpAlu,
        grpJump,
        grpCall,
        grpReturn,
        grpStack,
        grpExchange,
        grpControl,
        grpCbPrefix,
        grpUnsupported,
        // groups for the byte after CB
        grpRotShift,
        grpIllegal,
        grpBit,
        grpRes,
        grpSet
    } instrGroupT;

    typedef enum logic [1:0] {
        stIdle,
        stFirst,
        stMore,
        stHold
    } fetchStateT;

endpackage

`default_nettype wire

/* hdl/z80Predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module z80Predecode import z80Pkg::*; (
    input  wire           clk,
    input  wire           rst,
    output logic          wbCyc,
    output logic          wbStb,
    output codeAddrT      wbAdr,
    input  wire codeByteT wbDatRd,
    input  wire           wbAck,
    output logic          instrValid,
    input  wire           instrReady,
    output codeAddrT      instrPc,
    output instrBytesT    instrBytes,
    output instrLenT      instrLen,
    output instrGroupT    instrGroup
);

    logic       fetchReq;
    logic       fetchDone;
    codeAddrT   fetchAddr;
    codeByteT   fetchByte;
    codeByteT   firstByte;
    codeByteT   secondByte;
    instrLenT   opLen;
    instrGroupT opGroup;
    instrGroupT cbGroup;

    busFetcher u_fetcher (
        .clk(clk),
        .rst(rst),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchByte(fetchByte),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAdr(wbAdr),
        .wbDatRd(wbDatRd),
        .wbAck(wbAck)
    );

    instrAssembler u_assembler (
        .clk(clk),
        .rst(rst),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchByte(fetchByte),
        .firstByte(firstByte),
        .secondByte(secondByte),
        .opLen(opLen),
        .opGroup(opGroup),
        .cbGroup(cbGroup),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .instrPc(instrPc),
        .instrBytes(instrBytes),
        .instrLen(instrLen),
        .instrGroup(instrGroup)
    );

    opcodeDecoder u_opDecoder (
        .opcode(firstByte),
        .len(opLen),
        .group(opGroup)
    );

    cbDecoder u_cbDecoder (
        .opcode(secondByte),
        .group(cbGroup)
    );

endmodule

`default_nettype wire

/* hdl/z80_cfg.svh */
`ifndef Z80_CFG_SVH
`define Z80_CFG_SVH

// code bus widths
`define Z80_ADDR_W 16
`define Z80_DATA_W 8

// longest unprefixed or CB instruction, in bytes
`define Z80_MAX_LEN 3

// first fetch address after reset
`define Z80_RESET_PC 0

`endif

/* vlog.f */
+incdir+hdl
hdl/z80Pkg.sv
hdl/opcodeDecoder.sv
hdl/cbDecoder.sv
hdl/busFetcher.sv
hdl/instrAssembler.sv
hdl/z80Predecode.sv
dv/wbCodeMemory.sv
dv/z80PredecodeTb.sv
